//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_csr_unit
FILELIST  ?= vlog.f

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- bench/csr_unit_chk.sv
`default_nettype none

module csr_unit_chk (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire csr_pkg::csr_cmd_e               cmd,
    input  wire logic [csr_pkg::CSR_ADDR_W-1:0]  addr,
    input  wire logic [csr_pkg::XLEN-1:0]        rdata,
    input  wire logic                            invalid,
    input  wire logic [1:0]                      priv
);

    timeunit 1ns;
    timeprecision 1ps;

    // No command, nothing to flag
    a_idle_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd == csr_pkg::CMD_NONE) |-> !invalid)
        else $error("invalid high while cmd is CMD_NONE");

    // Nothing in scope leaves machine mode
    a_priv_machine: assert property (@(posedge clk) disable iff (!rst_n)
        priv == csr_pkg::PRIV_MACHINE)
        else $error("priv left machine mode");

    // Plain read or outside the read-only quarter, so the address is unknown
    a_unknown_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (invalid && ((cmd == csr_pkg::CMD_READ) || (addr[11:10] != 2'b11)))
            |-> (rdata == '0))
        else $error("unknown address returned nonzero read data");

endmodule

`default_nettype wire

//--- bench/tb_csr_unit.sv
`default_nettype none

module tb_csr_unit;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        csr_pkg::csr_cmd_e               cmd;
        logic [csr_pkg::CSR_ADDR_W-1:0]  addr;
        logic [csr_pkg::XLEN-1:0]        wdata;
        logic                            incr;
        logic [csr_pkg::XLEN-1:0]        exp_rdata;
        logic                            chk_rdata;  // Writes leave rdata unchecked
        logic                            exp_invalid;
        string                           name;
    } entry_t;

    logic                            clk;
    logic                            rst_n;
    csr_pkg::csr_cmd_e               cmd;
    logic [csr_pkg::CSR_ADDR_W-1:0]  addr;
    logic [csr_pkg::XLEN-1:0]        wdata;
    logic                            instret_incr;
    logic [csr_pkg::XLEN-1:0]        rdata;
    logic                            invalid;
    logic [1:0]                      priv;
    csr_pkg::mstatus_t               mstatus_o;

    entry_t table_q[$];
    int     cycles = 0;
    int     cycle_limit = 1000;  // Replaced once the table is built

    csr_unit UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .addr         (addr),
        .wdata        (wdata),
        .instret_incr (instret_incr),
        .rdata        (rdata),
        .invalid      (invalid),
        .priv         (priv),
        .mstatus      (mstatus_o)
    );

    bind csr_unit csr_unit_chk u_chk (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd     (cmd),
        .addr    (addr),
        .rdata   (rdata),
        .invalid (invalid),
        .priv    (priv)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("RESULT: FAIL");
            $fatal(1, "Timeout, the test table did not finish within %0d cycles", cycle_limit);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic add_entry(input csr_pkg::csr_cmd_e c, input logic [11:0] a,
                             input logic [31:0] w, input logic inc, input logic [31:0] exp,
                             input logic chk, input logic inv, input string name);
        entry_t e;
        e.cmd = c;
        e.addr = a;
        e.wdata = w;
        e.incr = inc;
        e.exp_rdata = exp;
        e.chk_rdata = chk;
        e.exp_invalid = inv;
        e.name = name;
        table_q.push_back(e);
    endtask

    // Drive on the falling edge, sample 10 ns before the rising edge
    task automatic apply_entry(input entry_t e);
        @(negedge clk);
        cmd          = e.cmd;
        addr         = e.addr;
        wdata        = e.wdata;
        instret_incr = e.incr;
        #40;
        if (e.chk_rdata)
            check_value(e.name, e.exp_rdata, rdata);
        check_value({e.name, "_invalid"}, 32'(e.exp_invalid), 32'(invalid));
        // Status ports mirror the register just read
        if (e.chk_rdata && (e.addr == csr_pkg::ADDR_MSTATUS))
            check_value({e.name, "_port"}, e.exp_rdata, mstatus_o);
        if (e.chk_rdata && (e.addr == csr_pkg::ADDR_PRIV))
            check_value({e.name, "_port"}, e.exp_rdata, 32'(priv));
    endtask

    task automatic build_table();
        // Reset values
        add_entry(csr_pkg::CMD_READ, 12'h300, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0, "rst_mstatus");
        add_entry(csr_pkg::CMD_READ, 12'h305, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0, "rst_mtvec");
        add_entry(csr_pkg::CMD_READ, 12'h340, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0, "rst_mscratch");
        add_entry(csr_pkg::CMD_READ, 12'h341, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0, "rst_mepc");
        add_entry(csr_pkg::CMD_READ, 12'h342, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0, "rst_mcause");
        add_entry(csr_pkg::CMD_READ, 12'h343, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0, "rst_mtval");
        add_entry(csr_pkg::CMD_READ, 12'hFC0, 32'h0, 1'b0, 32'h3, 1'b1, 1'b0, "rst_priv");
        add_entry(csr_pkg::CMD_READ, 12'hF11, 32'h0, 1'b0, csr_pkg::MVENDORID, 1'b1, 1'b0,
                  "vendor");
        add_entry(csr_pkg::CMD_READ, 12'hF12, 32'h0, 1'b0, csr_pkg::MARCHID, 1'b1, 1'b0, "arch");
        add_entry(csr_pkg::CMD_READ, 12'hF13, 32'h0, 1'b0, csr_pkg::MIMPID, 1'b1, 1'b0, "impl");
        add_entry(csr_pkg::CMD_READ, 12'hF14, 32'h0, 1'b0, csr_pkg::MHARTID, 1'b1, 1'b0, "hart");
        add_entry(csr_pkg::CMD_READ, 12'h301, 32'h0, 1'b0, csr_pkg::MISA_BASE, 1'b1, 1'b0,
                  "rst_misa");
        // Data registers, then set and clear on mscratch
        add_entry(csr_pkg::CMD_WRITE, 12'h340, 32'h12345678, 1'b0, 32'h0, 1'b0, 1'b0, "wr_scratch");
        add_entry(csr_pkg::CMD_READ, 12'h340, 32'h0, 1'b0, 32'h12345678, 1'b1, 1'b0, "rd_scratch");
        add_entry(csr_pkg::CMD_WRITE, 12'h342, 32'h8000000B, 1'b0, 32'h0, 1'b0, 1'b0, "wr_mcause");
        add_entry(csr_pkg::CMD_READ, 12'h342, 32'h0, 1'b0, 32'h8000000B, 1'b1, 1'b0, "rd_mcause");
        add_entry(csr_pkg::CMD_WRITE, 12'h343, 32'hDEADBEEF, 1'b0, 32'h0, 1'b0, 1'b0, "wr_mtval");
        add_entry(csr_pkg::CMD_READ, 12'h343, 32'h0, 1'b0, 32'hDEADBEEF, 1'b1, 1'b0, "rd_mtval");
        add_entry(csr_pkg::CMD_READ_SET, 12'h340, 32'h000000FF, 1'b0, 32'h12345678, 1'b1, 1'b0,
                  "set_old");
        add_entry(csr_pkg::CMD_READ, 12'h340, 32'h0, 1'b0, 32'h123456FF, 1'b1, 1'b0, "set_new");
        add_entry(csr_pkg::CMD_READ_CLEAR, 12'h340, 32'h0000F0F0, 1'b0, 32'h123456FF, 1'b1, 1'b0,
                  "clr_old");
        add_entry(csr_pkg::CMD_READ, 12'h340, 32'h0, 1'b0, 32'h1234060F, 1'b1, 1'b0, "clr_new");
        // Alignment of mtvec and mepc
        add_entry(csr_pkg::CMD_WRITE, 12'h305, 32'h00001000, 1'b0, 32'h0, 1'b0, 1'b0, "wr_mtvec");
        add_entry(csr_pkg::CMD_READ, 12'h305, 32'h0, 1'b0, 32'h00001000, 1'b1, 1'b0, "rd_mtvec");
        add_entry(csr_pkg::CMD_WRITE, 12'h305, 32'h00002001, 1'b0, 32'h0, 1'b0, 1'b0, "mtvec_odd");
        add_entry(csr_pkg::CMD_READ, 12'h305, 32'h0, 1'b0, 32'h00001000, 1'b1, 1'b0, "mtvec_kept");
        add_entry(csr_pkg::CMD_WRITE, 12'h341, 32'h00000400, 1'b0, 32'h0, 1'b0, 1'b0, "wr_mepc");
        add_entry(csr_pkg::CMD_WRITE, 12'h341, 32'h00000402, 1'b0, 32'h0, 1'b0, 1'b0, "mepc_odd");
        add_entry(csr_pkg::CMD_READ, 12'h341, 32'h0, 1'b0, 32'h00000400, 1'b1, 1'b0, "mepc_kept");
        // Field masks and the reserved MPP value
        add_entry(csr_pkg::CMD_WRITE, 12'h300, 32'hFFFFFFFF, 1'b0, 32'h0, 1'b0, 1'b0, "mst_ones");
        add_entry(csr_pkg::CMD_READ, 12'h300, 32'h0, 1'b0, csr_pkg::MSTATUS_MASK, 1'b1, 1'b0,
                  "mst_mask");
        add_entry(csr_pkg::CMD_WRITE, 12'h300, 32'h00001000, 1'b0, 32'h0, 1'b0, 1'b0, "mpp_rsvd");
        add_entry(csr_pkg::CMD_READ, 12'h300, 32'h0, 1'b0, 32'h00001800, 1'b1, 1'b0, "mpp_kept");
        add_entry(csr_pkg::CMD_WRITE, 12'h301, 32'hFFFFFFFF, 1'b0, 32'h0, 1'b0, 1'b0, "misa_ones");
        add_entry(csr_pkg::CMD_READ, 12'h301, 32'h0, 1'b0, csr_pkg::MISA_BASE | 32'h1, 1'b1, 1'b0,
                  "misa_a_set");
        add_entry(csr_pkg::CMD_READ_CLEAR, 12'h301, 32'h1, 1'b0, csr_pkg::MISA_BASE | 32'h1,
                  1'b1, 1'b0, "misa_clr_old");
        add_entry(csr_pkg::CMD_READ, 12'h301, 32'h0, 1'b0, csr_pkg::MISA_BASE, 1'b1, 1'b0,
                  "misa_a_clr");
        // Legality
        add_entry(csr_pkg::CMD_READ, 12'h7C0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b1, "rd_unknown");
        add_entry(csr_pkg::CMD_WRITE, 12'h7C0, 32'hFFFFFFFF, 1'b0, 32'h0, 1'b0, 1'b1, "wr_unknown");
        add_entry(csr_pkg::CMD_NONE, 12'h7C0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, "idle_unknown");
        add_entry(csr_pkg::CMD_WRITE, 12'hF11, 32'hFFFFFFFF, 1'b0, 32'h0, 1'b0, 1'b1, "wr_vendor");
        add_entry(csr_pkg::CMD_READ, 12'hF11, 32'h0, 1'b0, csr_pkg::MVENDORID, 1'b1, 1'b0,
                  "vendor_kept");
        add_entry(csr_pkg::CMD_READ_SET, 12'hFC0, 32'hFFFFFFFF, 1'b0, 32'h3, 1'b1, 1'b1,
                  "set_priv");
        add_entry(csr_pkg::CMD_WRITE, 12'hFC0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, "wr_priv");
        add_entry(csr_pkg::CMD_READ, 12'hFC0, 32'h0, 1'b0, 32'h3, 1'b1, 1'b0, "priv_kept");
        // Counters
        add_entry(csr_pkg::CMD_WRITE, 12'hB00, 32'h00000100, 1'b0, 32'h0, 1'b0, 1'b0, "wr_cycle");
        add_entry(csr_pkg::CMD_READ, 12'hB00, 32'h0, 1'b0, 32'h00000100, 1'b1, 1'b0, "cycle_w");
        add_entry(csr_pkg::CMD_READ, 12'hB00, 32'h0, 1'b0, 32'h00000101, 1'b1, 1'b0, "cycle_w1");
        add_entry(csr_pkg::CMD_WRITE, 12'hB80, 32'h00000005, 1'b0, 32'h0, 1'b0, 1'b0, "wr_cycleh");
        add_entry(csr_pkg::CMD_READ, 12'hB80, 32'h0, 1'b0, 32'h00000005, 1'b1, 1'b0, "cycleh_w");
        add_entry(csr_pkg::CMD_READ, 12'hB02, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0, "instret_0");
        add_entry(csr_pkg::CMD_NONE, 12'h000, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, "retire_1");
        add_entry(csr_pkg::CMD_NONE, 12'h000, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, "no_retire");
        add_entry(csr_pkg::CMD_NONE, 12'h000, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, "retire_2");
        add_entry(csr_pkg::CMD_NONE, 12'h000, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, "retire_3");
        add_entry(csr_pkg::CMD_READ, 12'hB02, 32'h0, 1'b0, 32'h3, 1'b1, 1'b0, "instret_3");
    endtask

    initial begin
        rst_n        = 1'b0;
        cmd          = csr_pkg::CMD_NONE;
        addr         = '0;
        wdata        = '0;
        instret_incr = 1'b0;
        build_table();
        cycle_limit = 5 + table_q.size() + 20;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (table_q[i])
            apply_entry(table_q[i]);
        @(negedge clk);
        cmd          = csr_pkg::CMD_NONE;
        instret_incr = 1'b0;
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/csr_counters.sv
`default_nettype none

module csr_counters (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                instret_incr,
    input  wire csr_pkg::csr_wr_t    wr,
    input  wire csr_pkg::csr_word_u  wword,
    output csr_pkg::csr_count_t      count
);

    localparam int CW = 2 * csr_pkg::XLEN;

    // Step the counter, then let a half write override that half
    function automatic logic [CW-1:0] next_count(
        input logic [CW-1:0]            cur,
        input logic                     step,
        input logic                     wr_lo,
        input logic                     wr_hi,
        input logic [csr_pkg::XLEN-1:0] w
    );
        logic [CW-1:0] nxt;
        nxt = cur + {{(CW-1){1'b0}}, step};
        if (wr_lo)
            nxt[csr_pkg::XLEN-1:0] = w;
        if (wr_hi)
            nxt[CW-1:csr_pkg::XLEN] = w;  // Other half keeps its stepped value
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count.cycle   <= next_count(count.cycle, 1'b1, wr.cycle, wr.cycleh, wword.raw);
            count.instret <= next_count(count.instret, instret_incr,
                                        wr.instret, wr.instreth, wword.raw);
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_decode.sv
`default_nettype none

module csr_decode (
    input  wire csr_pkg::csr_cmd_e               cmd,
    input  wire logic [csr_pkg::CSR_ADDR_W-1:0]  addr,
    input  wire logic [csr_pkg::XLEN-1:0]        wdata,
    input  wire logic [csr_pkg::XLEN-1:0]        rdata,  // Old value for set and clear
    output csr_pkg::csr_sel_e                    sel,
    output logic                                 invalid,
    output csr_pkg::csr_wr_t                     wr,
    output csr_pkg::csr_word_u                   wword
);

    logic is_rd;
    logic is_wr;
    logic ro_range;
    logic wr_ok;
    logic aligned;

    // Address to register select, unknown falls to SEL_NONE
    always_comb begin
        case (addr)
            csr_pkg::ADDR_MSTATUS:   sel = csr_pkg::SEL_MSTATUS;
            csr_pkg::ADDR_MISA:      sel = csr_pkg::SEL_MISA;
            csr_pkg::ADDR_MTVEC:     sel = csr_pkg::SEL_MTVEC;
            csr_pkg::ADDR_MSCRATCH:  sel = csr_pkg::SEL_MSCRATCH;
            csr_pkg::ADDR_MEPC:      sel = csr_pkg::SEL_MEPC;
            csr_pkg::ADDR_MCAUSE:    sel = csr_pkg::SEL_MCAUSE;
            csr_pkg::ADDR_MTVAL:     sel = csr_pkg::SEL_MTVAL;
            csr_pkg::ADDR_CYCLE:     sel = csr_pkg::SEL_CYCLE;
            csr_pkg::ADDR_CYCLEH:    sel = csr_pkg::SEL_CYCLEH;
            csr_pkg::ADDR_INSTRET:   sel = csr_pkg::SEL_INSTRET;
            csr_pkg::ADDR_INSTRETH:  sel = csr_pkg::SEL_INSTRETH;
            csr_pkg::ADDR_MVENDORID: sel = csr_pkg::SEL_MVENDORID;
            csr_pkg::ADDR_MARCHID:   sel = csr_pkg::SEL_MARCHID;
            csr_pkg::ADDR_MIMPID:    sel = csr_pkg::SEL_MIMPID;
            csr_pkg::ADDR_MHARTID:   sel = csr_pkg::SEL_MHARTID;
            csr_pkg::ADDR_PRIV:      sel = csr_pkg::SEL_PRIV;
            default:                 sel = csr_pkg::SEL_NONE;
        endcase
    end

    // Plain write is the only command that skips the read
    assign is_rd = (cmd == csr_pkg::CMD_READ) || (cmd == csr_pkg::CMD_READ_WRITE) ||
                   (cmd == csr_pkg::CMD_READ_SET) || (cmd == csr_pkg::CMD_READ_CLEAR);
    assign is_wr = (cmd == csr_pkg::CMD_WRITE) || (cmd == csr_pkg::CMD_READ_WRITE) ||
                   (cmd == csr_pkg::CMD_READ_SET) || (cmd == csr_pkg::CMD_READ_CLEAR);

    assign ro_range = (addr[11:10] == 2'b11); // Top quarter of the space is read only
    assign invalid  = (is_rd || is_wr) && ((sel == csr_pkg::SEL_NONE) || (is_wr && ro_range));
    assign wr_ok    = is_wr && !invalid;

    // Read-modify-write word
    always_comb begin
        case (cmd)
            csr_pkg::CMD_READ_SET:   wword.raw = rdata | wdata;
            csr_pkg::CMD_READ_CLEAR: wword.raw = rdata & ~wdata;
            default:                 wword.raw = wdata;  // WRITE, READ_WRITE
        endcase
    end

    assign aligned = (wword.raw[1:0] == 2'b00); // Trap vector and EPC are word aligned

    always_comb begin
        wr = '0;
        if (wr_ok) begin
            case (sel)
                csr_pkg::SEL_MSTATUS:  wr.mstatus  = 1'b1;
                csr_pkg::SEL_MISA:     wr.misa     = 1'b1;
                csr_pkg::SEL_MTVEC:    wr.mtvec    = aligned; // Misaligned write dropped silently
                csr_pkg::SEL_MSCRATCH: wr.mscratch = 1'b1;
                csr_pkg::SEL_MEPC:     wr.mepc     = aligned;
                csr_pkg::SEL_MCAUSE:   wr.mcause   = 1'b1;
                csr_pkg::SEL_MTVAL:    wr.mtval    = 1'b1;
                csr_pkg::SEL_CYCLE:    wr.cycle    = 1'b1;
                csr_pkg::SEL_CYCLEH:   wr.cycleh   = 1'b1;
                csr_pkg::SEL_INSTRET:  wr.instret  = 1'b1;
                csr_pkg::SEL_INSTRETH: wr.instreth = 1'b1;
                default: ;  // ID and priv never reach here, read only
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_machine_regs.sv
`default_nettype none

module csr_machine_regs (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire csr_pkg::csr_wr_t    wr,
    input  wire csr_pkg::csr_word_u  wword,
    output csr_pkg::csr_mstate_t     state
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= '0;
            state.priv <= csr_pkg::PRIV_MACHINE; // Core starts in machine mode
        end else begin
            // mstatus, field view of the write word, pads stay zero
            if (wr.mstatus) begin
                state.mstatus.tsr  <= wword.mstatus.tsr;
                state.mstatus.tw   <= wword.mstatus.tw;
                state.mstatus.tvm  <= wword.mstatus.tvm;
                state.mstatus.mxr  <= wword.mstatus.mxr;
                state.mstatus.sum  <= wword.mstatus.sum;
                state.mstatus.mprv <= wword.mstatus.mprv;
                if (wword.mstatus.mpp != csr_pkg::PRIV_RESERVED)
                    state.mstatus.mpp <= wword.mstatus.mpp; // WARL, reserved keeps old
                state.mstatus.spp  <= wword.mstatus.spp;
                state.mstatus.mpie <= wword.mstatus.mpie;
                state.mstatus.spie <= wword.mstatus.spie;
                state.mstatus.mie  <= wword.mstatus.mie;
                state.mstatus.sie  <= wword.mstatus.sie;
            end

            if (wr.misa)
                state.misa_a <= wword.raw[0]; // Only A is writable

            // Raw view for the full word registers
            if (wr.mtvec)
                state.mtvec <= wword.raw;
            if (wr.mscratch)
                state.mscratch <= wword.raw;
            if (wr.mepc)
                state.mepc <= wword.raw;
            if (wr.mcause)
                state.mcause <= wword.raw;
            if (wr.mtval)
                state.mtval <= wword.raw;

            // No trap or return path here, priv holds machine
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // Command from the execute stage, one cycle strobe
    typedef enum logic [3:0] {
        CMD_NONE       = 4'd0,
        CMD_READ       = 4'd1,
        CMD_WRITE      = 4'd2,
        CMD_READ_WRITE = 4'd3,
        CMD_READ_SET   = 4'd4,
        CMD_READ_CLEAR = 4'd5
    } csr_cmd_e;

    // Machine mode addresses
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLE     = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLEH    = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRET   = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRETH  = 12'hB82;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID   = 12'hF14;
    localparam logic [CSR_ADDR_W-1:0] ADDR_PRIV      = 12'hFC0; // Custom, read only

    // Identification words
    localparam logic [XLEN-1:0] MVENDORID = 32'h0A1A_A1E0;
    localparam logic [XLEN-1:0] MARCHID   = 32'h0000_0001;
    localparam logic [XLEN-1:0] MIMPID    = 32'h0000_0001;
    localparam logic [XLEN-1:0] MHARTID   = 32'h0000_0000;

    // MXL=1 (32 bit), U S M I present, A bit added at read time
    localparam logic [XLEN-1:0] MISA_BASE    = 32'h4014_1100;
    // Writable mstatus bits 22..17, 12..11, 8, 7, 5, 3, 1
    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h007E_19AA;

    localparam logic [1:0] PRIV_USER       = 2'b00;
    localparam logic [1:0] PRIV_SUPERVISOR = 2'b01;
    localparam logic [1:0] PRIV_RESERVED   = 2'b10; // Ignored on MPP write
    localparam logic [1:0] PRIV_MACHINE    = 2'b11;

    typedef enum logic [4:0] {
        SEL_NONE, SEL_MSTATUS, SEL_MISA, SEL_MTVEC, SEL_MSCRATCH, SEL_MEPC,
        SEL_MCAUSE, SEL_MTVAL, SEL_CYCLE, SEL_CYCLEH, SEL_INSTRET, SEL_INSTRETH,
        SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID, SEL_PRIV
    } csr_sel_e;

    // Bit exact image of the mstatus word
    typedef struct packed {
        logic [8:0] pad_31_23;  // SD and WPRI
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mxr;
        logic       sum;
        logic       mprv;
        logic [3:0] pad_16_13;  // XS, FS hardwired zero
        logic [1:0] mpp;
        logic [1:0] pad_10_9;
        logic       spp;
        logic       mpie;
        logic       pad_6;
        logic       spie;
        logic       pad_4;
        logic       mie;
        logic       pad_2;
        logic       sie;
        logic       pad_0;
    } mstatus_t;

    typedef union packed {
        logic [XLEN-1:0] raw;
        mstatus_t        mstatus;
    } csr_word_u;

    typedef struct packed {
        logic mstatus;
        logic misa;
        logic mtvec;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic cycle;
        logic cycleh;
        logic instret;
        logic instreth;
    } csr_wr_t;

    typedef struct packed {
        mstatus_t        mstatus;
        logic            misa_a;   // Scratch A bit, emulated atomics
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mscratch;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
        logic [1:0]      priv;
    } csr_mstate_t;

    typedef struct packed {
        logic [2*XLEN-1:0] cycle;
        logic [2*XLEN-1:0] instret;
    } csr_count_t;

endpackage

`default_nettype wire

//--- hw/csr_read_mux.sv
`default_nettype none

module csr_read_mux (
    input  wire csr_pkg::csr_sel_e      sel,
    input  wire csr_pkg::csr_mstate_t   state,
    input  wire csr_pkg::csr_count_t    count,
    output logic [csr_pkg::XLEN-1:0]    rdata
);

    localparam int XW = csr_pkg::XLEN;

    always_comb begin
        case (sel)
            // Register image already carries the zero pads
            csr_pkg::SEL_MSTATUS:   rdata = state.mstatus;
            csr_pkg::SEL_MISA:      rdata = csr_pkg::MISA_BASE | {{(XW-1){1'b0}}, state.misa_a};
            csr_pkg::SEL_MTVEC:     rdata = state.mtvec;
            csr_pkg::SEL_MSCRATCH:  rdata = state.mscratch;
            csr_pkg::SEL_MEPC:      rdata = state.mepc;
            csr_pkg::SEL_MCAUSE:    rdata = state.mcause;
            csr_pkg::SEL_MTVAL:     rdata = state.mtval;

            // Counter halves
            csr_pkg::SEL_CYCLE:     rdata = count.cycle[XW-1:0];
            csr_pkg::SEL_CYCLEH:    rdata = count.cycle[2*XW-1:XW];
            csr_pkg::SEL_INSTRET:   rdata = count.instret[XW-1:0];
            csr_pkg::SEL_INSTRETH:  rdata = count.instret[2*XW-1:XW];

            // Fixed identification
            csr_pkg::SEL_MVENDORID: rdata = csr_pkg::MVENDORID;
            csr_pkg::SEL_MARCHID:   rdata = csr_pkg::MARCHID;
            csr_pkg::SEL_MIMPID:    rdata = csr_pkg::MIMPID;
            csr_pkg::SEL_MHARTID:   rdata = csr_pkg::MHARTID;

            csr_pkg::SEL_PRIV:      rdata = {{(XW-2){1'b0}}, state.priv};
            default:                rdata = '0;  // Unknown address reads zero
        endcase
    end

endmodule

`default_nettype wire

//--- hw/csr_unit.sv
`default_nettype none

module csr_unit (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire csr_pkg::csr_cmd_e               cmd,
    input  wire logic [csr_pkg::CSR_ADDR_W-1:0]  addr,
    input  wire logic [csr_pkg::XLEN-1:0]        wdata,
    input  wire logic                            instret_incr,  // One per retired instruction
    output logic [csr_pkg::XLEN-1:0]             rdata,
    output logic                                 invalid,
    output logic [1:0]                           priv,
    output csr_pkg::mstatus_t                    mstatus        // Trap and MMU control bits
);

    csr_pkg::csr_sel_e    sel;
    csr_pkg::csr_wr_t     wr;
    csr_pkg::csr_word_u   wword;
    csr_pkg::csr_mstate_t mstate;
    csr_pkg::csr_count_t  count;

    csr_decode u_decode (
        .cmd     (cmd),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),  // Fed back for set and clear
        .sel     (sel),
        .invalid (invalid),
        .wr      (wr),
        .wword   (wword)
    );

    csr_machine_regs u_machine_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .wword (wword),
        .state (mstate)
    );

    csr_counters u_counters (
        .clk          (clk),
        .rst_n        (rst_n),
        .instret_incr (instret_incr),
        .wr           (wr),
        .wword        (wword),
        .count        (count)
    );

    csr_read_mux u_read_mux (
        .sel   (sel),
        .state (mstate),
        .count (count),
        .rdata (rdata)
    );

    assign priv    = mstate.priv;
    assign mstatus = mstate.mstatus;

endmodule

`default_nettype wire

//--- vlog.f
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_machine_regs.sv
hw/csr_counters.sv
hw/csr_read_mux.sv
hw/csr_unit.sv
bench/csr_unit_chk.sv
bench/tb_csr_unit.sv
